// ==== source/uart_pkg.sv ====
package uart_pkg;

    // system clocks per serial bit, 3.125 Mbaud at 50 MHz
    localparam int clks_per_bit = 16;

    // start edge to start bit center
    localparam int half_bit = clks_per_bit / 2;

    // 8N1 frame payload
    localparam int data_bits = 8;

    // clock position inside one bit period
    typedef logic [$clog2(clks_per_bit)-1:0] bit_clk_t;

    // index of the data bit being received
    typedef logic [$clog2(data_bits)-1:0] bit_index_t;

    typedef logic [data_bits-1:0] uart_byte_t;

    // one received byte, valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } rx_byte_s;

endpackage

// ==== source/mmio_pkg.sv ====
package mmio_pkg;

    // ring geometry
    localparam int ring_words = 256;
    localparam int ring_bytes = ring_words * 4;

    typedef logic [11:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [$clog2(ring_words)-1:0] word_index_t;
    typedef logic [$clog2(ring_bytes)-1:0] byte_pos_t;
    typedef logic [31:0] count_t;

    // address map, ring window is read only
    localparam addr_t buffer_base  = 12'h000;
    localparam addr_t buffer_size  = 12'h400;
    localparam addr_t tail_offset  = 12'h400;
    localparam addr_t count_offset = 12'h404;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_s;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_s;

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx,
    output uart_pkg::rx_byte_s byte_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t               state;
    logic                 rx_meta;
    logic                 rx_sync;
    uart_pkg::bit_clk_t   clk_cnt;
    uart_pkg::bit_index_t bit_idx;
    uart_pkg::uart_byte_t shift_reg;
    logic                 valid;
    logic                 start_center;
    logic                 bit_center;

    // rx is asynchronous to clk, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign start_center = clk_cnt == uart_pkg::bit_clk_t'(uart_pkg::half_bit - 1);
    assign bit_center   = clk_cnt == uart_pkg::bit_clk_t'(uart_pkg::clks_per_bit - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    // still low at mid start bit, otherwise a glitch
                    if (start_center) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? st_idle : st_data;
                    end
                end
                st_data: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_center) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_pkg::bit_index_t'(uart_pkg::data_bits - 1)) begin
                            state <= st_stop;
                        end
                    end
                end
                default: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    // stop bit level is not checked
                    if (bit_center) begin
                        valid <= 1'b1;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == st_data && bit_center) begin
            shift_reg <= {rx_sync, shift_reg[uart_pkg::data_bits-1:1]};
        end
    end

    assign byte_out = '{valid: valid, data: shift_reg};

endmodule

// ==== source/rx_buffer.sv ====
`timescale 1ns/1ns

module rx_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  uart_pkg::rx_byte_s    byte_in,
    input  mmio_pkg::word_index_t rd_index,
    output mmio_pkg::word_t       rd_word,
    input  logic                  count_clear,
    output mmio_pkg::byte_pos_t   tail,
    output mmio_pkg::count_t      count
);

    typedef enum logic {
        st_idle,
        st_merge
    } state_t;

    state_t                state;
    mmio_pkg::word_t       mem [mmio_pkg::ring_words];
    mmio_pkg::word_t       old_word;
    mmio_pkg::word_t       merged_word;
    uart_pkg::uart_byte_t  new_byte;
    mmio_pkg::word_index_t wr_index;
    logic [1:0]            lane;
    logic                  commit;

    // upper tail bits pick the word, low bits the byte lane
    assign wr_index = tail[9:2];
    assign lane     = tail[1:0];
    assign commit   = state == st_merge;

    // little endian packing into the word read back
    always_comb begin
        merged_word = old_word;
        merged_word[{lane, 3'b000} +: 8] = new_byte;
    end

    always_ff @(posedge clk) begin
        // bus read port, one cycle latency
        rd_word <= mem[rd_index];
        if (state == st_idle && byte_in.valid) begin
            old_word <= mem[wr_index];
            new_byte <= byte_in.data;
        end
        if (commit) begin
            mem[wr_index] <= merged_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            tail  <= '0;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (byte_in.valid) begin
                        state <= st_merge;
                    end
                end
                default: begin
                    state <= st_idle;
                    // wraps at 1024 bytes
                    tail  <= tail + 1'b1;
                end
            endcase

            // a byte landing on the clear edge still counts
            if (count_clear) begin
                count <= commit ? mmio_pkg::count_t'(1) : '0;
            end else if (commit) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== source/rx_apb_port.sv ====
`timescale 1ns/1ns

module rx_apb_port (
    input  logic                  clk,
    input  logic                  reset,
    input  mmio_pkg::apb_req_s    req,
    output mmio_pkg::apb_rsp_s    rsp,
    output mmio_pkg::word_index_t rd_index,
    input  mmio_pkg::word_t       rd_word,
    input  mmio_pkg::byte_pos_t   tail,
    input  mmio_pkg::count_t      count,
    output logic                  count_clear
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_respond
    } state_t;

    state_t          state;
    logic            hit_buffer;
    logic            hit_tail;
    logic            hit_count;
    logic            access_err;
    mmio_pkg::word_t read_mux;
    logic            pready;
    logic            pslverr;
    mmio_pkg::word_t prdata;

    // address decode
    assign hit_buffer = (req.paddr - mmio_pkg::buffer_base) < mmio_pkg::buffer_size;
    assign hit_tail   = req.paddr == mmio_pkg::tail_offset;
    assign hit_count  = req.paddr == mmio_pkg::count_offset;

    // only count is writable
    assign access_err = req.pwrite ? !hit_count : !(hit_buffer || hit_tail || hit_count);

    // ring word is fetched during setup, ready in the first access cycle
    assign rd_index = req.paddr[9:2];

    always_comb begin
        read_mux = '0;
        if (hit_buffer) begin
            read_mux = rd_word;
        end else if (hit_tail) begin
            read_mux = mmio_pkg::word_t'(tail);
        end else if (hit_count) begin
            read_mux = count;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            pready      <= 1'b0;
            pslverr     <= 1'b0;
            count_clear <= 1'b0;
        end else begin
            count_clear <= 1'b0;
            case (state)
                st_idle: begin
                    // setup phase seen
                    if (req.psel && !req.penable) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // first access cycle is the wait state
                    state       <= st_respond;
                    pready      <= 1'b1;
                    pslverr     <= access_err;
                    count_clear <= req.pwrite && hit_count;
                end
                default: begin
                    state   <= st_idle;
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait) begin
            prdata <= (!req.pwrite && !access_err) ? read_mux : '0;
        end
    end

    assign rsp = '{pready: pready, prdata: prdata, pslverr: pslverr};

endmodule

// ==== source/uart_rx_mmio.sv ====
`timescale 1ns/1ns

module uart_rx_mmio (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx,
    input  mmio_pkg::apb_req_s req,
    output mmio_pkg::apb_rsp_s rsp
);

    uart_pkg::rx_byte_s    rx_byte;
    mmio_pkg::word_index_t rd_index;
    mmio_pkg::word_t       rd_word;
    mmio_pkg::byte_pos_t   tail;
    mmio_pkg::count_t      count;
    logic                  count_clear;

    uart_rx i_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .byte_out (rx_byte)
    );

    rx_buffer i_rx_buffer (
        .clk         (clk),
        .reset       (reset),
        .byte_in     (rx_byte),
        .rd_index    (rd_index),
        .rd_word     (rd_word),
        .count_clear (count_clear),
        .tail        (tail),
        .count       (count)
    );

    rx_apb_port i_rx_apb_port (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .rsp         (rsp),
        .rd_index    (rd_index),
        .rd_word     (rd_word),
        .tail        (tail),
        .count       (count),
        .count_clear (count_clear)
    );

endmodule

// ==== tb/tb_uart_rx_mmio.sv ====
`timescale 1ns/1ns

module tb_uart_rx_mmio;

    logic               clk = 1'b0;
    logic               reset;
    logic               rx;
    mmio_pkg::apb_req_s req;
    mmio_pkg::apb_rsp_s rsp;

    // byte model of the ring, known marks lanes written so far
    uart_pkg::uart_byte_t ring_model [mmio_pkg::ring_bytes];
    logic                 ring_known [mmio_pkg::ring_bytes];
    mmio_pkg::byte_pos_t  model_tail = '0;

    logic [7:0]      cmd_q [$];
    mmio_pkg::word_t arg_a [$];
    mmio_pkg::word_t arg_b [$];

    int errors = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    uart_rx_mmio i_uart_rx_mmio (.clk(clk), .reset(reset), .rx(rx), .req(req), .rsp(rsp));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_word(input string name, input mmio_pkg::word_t got,
                              input mmio_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    // setup cycle, then access cycles until pready
    task automatic apb_access(input mmio_pkg::addr_t addr, input logic write,
                              input mmio_pkg::word_t wdata,
                              output mmio_pkg::word_t rdata, output logic err);
        int cycles;
        @(posedge clk);
        req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        req.penable <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rsp.pready);
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        if (cycles != 2) begin
            $display("apb response at %h came after %0d access cycles, not 2", addr, cycles);
            test_errors++;
        end
        @(posedge clk);
        req <= '0;
    endtask

    task automatic send_byte(input uart_pkg::uart_byte_t data);
        logic [9:0] frame;
        int         gap;
        // start bit, data lsb first, stop bit
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[0];
            frame = frame >> 1;
            repeat (uart_pkg::clks_per_bit - 1) @(posedge clk);
        end
        ring_model[model_tail] = data;
        ring_known[model_tail] = 1'b1;
        model_tail++;
        gap = $urandom_range(40, 0);
        repeat (gap) @(posedge clk);
    endtask

    task automatic send_glitch(input int len);
        @(posedge clk);
        rx <= 1'b0;
        repeat (len) @(posedge clk);
        rx <= 1'b1;
        repeat (2 * uart_pkg::clks_per_bit) @(posedge clk);
    endtask

    // lanes never written are don't care
    function automatic mmio_pkg::word_t model_word(input mmio_pkg::addr_t addr,
                                                   input mmio_pkg::word_t got);
        mmio_pkg::word_t w;
        w = got;
        for (int lane = 0; lane < 4; lane++) begin
            if (ring_known[{addr[9:2], 2'(lane)}]) begin
                w[lane*8 +: 8] = ring_model[{addr[9:2], 2'(lane)}];
            end
        end
        return w;
    endfunction

    task automatic finish_test(input int id);
        if (test_errors == 0) begin
            $display("test %0d passed", id);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", id, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic load_commands(input int fd);
        int               code;
        logic [7:0]       c;
        mmio_pkg::word_t  a;
        mmio_pkg::word_t  b;
        logic [8*128-1:0] line_buf;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", c);
            if (code != 1) break;
            if (c == "#") begin
                code = $fgets(line_buf, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, b);
                cmd_q.push_back(c);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_commands();
        mmio_pkg::word_t rdata;
        logic            err;
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "S": begin
                    for (int n = 0; n < int'(arg_b[i]); n++) begin
                        send_byte(uart_pkg::uart_byte_t'(arg_a[i] + n));
                    end
                end
                "R", "M": begin
                    apb_access(mmio_pkg::addr_t'(arg_a[i]), 1'b0, '0, rdata, err);
                    check_err("pslverr", err, 1'b0);
                    if (cmd_q[i] == "R") begin
                        check_word("prdata", rdata, arg_b[i]);
                    end else begin
                        check_word("prdata", rdata,
                                   model_word(mmio_pkg::addr_t'(arg_a[i]), rdata));
                    end
                end
                "W": begin
                    apb_access(mmio_pkg::addr_t'(arg_a[i]), 1'b1, arg_b[i], rdata, err);
                    check_err("pslverr", err, 1'b0);
                end
                "E": begin
                    apb_access(mmio_pkg::addr_t'(arg_a[i]), arg_b[i] != 0, 32'hffff_ffff,
                               rdata, err);
                    check_err("pslverr", err, 1'b1);
                    check_word("prdata", rdata, '0);
                end
                "G": send_glitch(int'(arg_a[i]));
                "T": finish_test(int'(arg_a[i]));
                default: begin
                    $display("unknown command %c in the stimulus file", cmd_q[i]);
                    test_errors++;
                end
            endcase
        end
    endtask

    initial begin
        wait (cycle_limit != 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout: run went past %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int fd;
        int steps;
        reset = 1'b1;
        rx    = 1'b1;
        req   = '0;
        void'($urandom(32'h49c41fc6));
        fd = $fopen("tb/uart_rx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file tb/uart_rx_stimulus.txt could not be opened");
            $display("Done: errors found");
            $finish;
        end else begin
            load_commands(fd);
            // each byte or command costs at most one frame plus gap and margin
            steps = 0;
            foreach (cmd_q[i]) begin
                steps += (cmd_q[i] == "S") ? int'(arg_b[i]) : 1;
            end
            cycle_limit = steps * (10 * uart_pkg::clks_per_bit + 40 + 10) + 200;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            run_commands();
            errors += test_errors;
            $display("%0d tests passed, %0d failed, %0d errors",
                     tests_passed, tests_failed, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// ==== tb/uart_rx_stimulus.txt ====
# cmd a b in hex: S first_byte count | R addr expected | M addr 0 (ring model) | W addr data
# E addr is_write (expect pslverr) | G low_clocks 0 (glitch) | T test_id 0 (end of test)
R 400 0
R 404 0
T 1 0
S 11 1
S 22 1
S 33 1
S 44 1
S 55 1
R 000 44332211
M 004 0
R 400 5
R 404 5
T 2 0
W 404 0
R 404 0
R 400 5
S a0 3
R 404 3
R 004 a2a1a055
T 3 0
S 00 3f8
R 400 0
R 008 03020100
S c1 3
R 000 44c3c2c1
M 3fc 0
R 400 3
R 404 3fe
T 4 0
E 000 1
E 400 1
E 408 0
E 408 1
R 400 3
R 404 3fe
M 000 0
T 5 0
G 4 0
R 400 3
R 404 3fe
S 5a 1
M 000 0
R 400 4
T 6 0

// ==== tb.f ====
source/uart_pkg.sv
source/mmio_pkg.sv
source/uart_rx.sv
source/rx_buffer.sv
source/rx_apb_port.sv
source/uart_rx_mmio.sv
tb/tb_uart_rx_mmio.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_uart_rx_mmio \
    -Mdir obj_dir -f tb.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

obj_dir/Vtb_uart_rx_mmio > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation ended abnormally, see sim.log"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi

echo "PASS"
exit 0
